// ==== logic/icache_params.svh ====
// width and size macros for the instruction fetch cache line store
// include wherever a width or the set count is needed

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address counted in quarter-line units
`define ICACHE_ADDR_W 16

// address split: quarter select, index, tag
`define ICACHE_QSEL_W 2
`define ICACHE_INDEX_W 4
`define ICACHE_TAG_W 10

// one quarter of a line, four quarters per line
`define ICACHE_QUARTER_W 32

`define ICACHE_SETS 16

`endif

// ==== logic/icache_pkg.sv ====
// shared types of the fetch cache line store
// modules pull these in with a wildcard import in their header

`include "icache_params.svh"

package icache_pkg;

  // quarter select in bits 1..0, index in 5..2, tag above
  typedef logic [`ICACHE_ADDR_W-1:0] fetch_addr_t;

  // fetch address without the quarter bits
  typedef logic [`ICACHE_ADDR_W-`ICACHE_QSEL_W-1:0] line_addr_t;

  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;

  typedef logic [`ICACHE_QUARTER_W-1:0] quarter_t;

  // lower half carries quarters 0 and 1
  typedef logic [2*`ICACHE_QUARTER_W-1:0] half_line_t;

  // quarter 0 sits in the lowest bits
  typedef logic [(1 << `ICACHE_QSEL_W)*`ICACHE_QUARTER_W-1:0] line_t;

endpackage

// ==== logic/icache_fill_assembler.sv ====
// builds one line commit out of two half-line fill beats
// also turns an invalidate request into a one-cycle commit

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_fill_assembler
  import icache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       fill_wen,
  input  logic       invalidate,
  input  line_addr_t fill_addr,
  input  half_line_t fill_data,
  output logic       commit_wen,
  output logic       commit_inv,
  output line_addr_t commit_addr,
  output line_t      commit_line
);

  localparam int HALF_W = $bits(half_line_t);

  // high while the second beat is on fill_data
  logic       fill_step;
  line_addr_t fill_addr_q;
  line_addr_t inv_addr_q;
  line_t      line_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_step  <= 1'b0;
      commit_wen <= 1'b0;
      commit_inv <= 1'b0;
    end else begin
      fill_step  <= fill_wen;
      // line is complete once the high half is in
      commit_wen <= fill_step;
      commit_inv <= invalidate;
    end
  end

  // address and line payload
  always_ff @(posedge clk) begin
    if (fill_wen) begin
      fill_addr_q          <= fill_addr;
      line_q[HALF_W-1:0]   <= fill_data;
    end
    if (fill_step) begin
      line_q[2*HALF_W-1:HALF_W] <= fill_data;
    end
    if (invalidate) begin
      inv_addr_q <= fill_addr;
    end
  end

  // invalidate keeps its own address so a fill in flight is not disturbed
  assign commit_addr = commit_inv ? inv_addr_q : fill_addr_q;
  assign commit_line = line_q;

  // a fill occupies two beats, so a new one cannot start right behind it
  a_fill_two_beats: assert property (@(posedge clk) disable iff (rst)
    fill_wen |=> !fill_wen);

endmodule

// ==== logic/icache_line_ram.sv ====
// direct mapped tag, valid and data arrays of the fetch cache
// serves two read lookups and a presence check, takes commits from the fill assembler

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_line_ram
  import icache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      a_read_en,
  input  logic                      b_read_en,
  input  fetch_addr_t               a_addr,
  input  fetch_addr_t               b_addr,
  input  logic                      commit_wen,
  input  logic                      commit_inv,
  input  line_addr_t                commit_addr,
  input  line_t                     commit_line,
  input  logic                      chk_en,
  input  line_addr_t                chk_addr,
  output logic                      a_hit,
  output logic                      b_hit,
  output line_t                     a_line,
  output line_t                     b_line,
  output logic [`ICACHE_QSEL_W-1:0] a_qsel,
  output logic [`ICACHE_QSEL_W-1:0] b_qsel,
  output logic                      chk_hit,
  output logic                      expun_wen,
  output line_addr_t                expun_addr
);

  logic [`ICACHE_SETS-1:0] valid_q;
  tag_t                    tag_q [`ICACHE_SETS];
  line_t                   data_q [`ICACHE_SETS];

  line_addr_t a_line_addr;
  line_addr_t b_line_addr;
  index_t     c_idx;
  tag_t       c_tag;
  logic       c_same_tag;
  logic       chk_en_q;
  line_addr_t chk_addr_q;

  function automatic index_t line_index(line_addr_t la);
    return la[`ICACHE_INDEX_W-1:0];
  endfunction

  function automatic tag_t line_tag(line_addr_t la);
    return la[$bits(line_addr_t)-1 -: `ICACHE_TAG_W];
  endfunction

  // valid entry with a matching tag
  function automatic logic lookup(line_addr_t la);
    return valid_q[line_index(la)] && (tag_q[line_index(la)] == line_tag(la));
  endfunction

  // drop the quarter bits
  assign a_line_addr = a_addr[`ICACHE_ADDR_W-1:`ICACHE_QSEL_W];
  assign b_line_addr = b_addr[`ICACHE_ADDR_W-1:`ICACHE_QSEL_W];

  assign c_idx      = line_index(commit_addr);
  assign c_tag      = line_tag(commit_addr);
  assign c_same_tag = tag_q[c_idx] == c_tag;

  // control state: hits, check pipe, expunge strobe, valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      a_hit     <= 1'b0;
      b_hit     <= 1'b0;
      chk_en_q  <= 1'b0;
      chk_hit   <= 1'b0;
      expun_wen <= 1'b0;
      valid_q   <= '0;
    end else begin
      a_hit     <= a_read_en && lookup(a_line_addr);
      b_hit     <= b_read_en && lookup(b_line_addr);
      chk_en_q  <= chk_en;
      chk_hit   <= chk_en_q && lookup(chk_addr_q);
      // a different valid tag gets pushed out by this fill
      expun_wen <= commit_wen && valid_q[c_idx] && !c_same_tag;
      if (commit_wen) begin
        valid_q[c_idx] <= 1'b1;
      end else if (commit_inv && c_same_tag) begin
        valid_q[c_idx] <= 1'b0;
      end
    end
  end

  // arrays and payload, reads see the contents before this edge's commit
  always_ff @(posedge clk) begin
    a_line     <= data_q[line_index(a_line_addr)];
    b_line     <= data_q[line_index(b_line_addr)];
    a_qsel     <= a_addr[`ICACHE_QSEL_W-1:0];
    b_qsel     <= b_addr[`ICACHE_QSEL_W-1:0];
    chk_addr_q <= chk_addr;
    expun_addr <= {tag_q[c_idx], c_idx};
    if (commit_wen) begin
      tag_q[c_idx]  <= c_tag;
      data_q[c_idx] <= commit_line;
    end
  end

  // the fill assembler must keep fills and invalidates apart
  a_commit_excl: assert property (@(posedge clk) disable iff (rst)
    !(commit_wen && commit_inv));

endmodule

// ==== logic/icache_quarter_select.sv ====
// picks the addressed quarter out of each looked-up line
// one register stage, result is zero when the lookup missed

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_quarter_select
  import icache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      a_hit_in,
  input  logic                      b_hit_in,
  input  line_t                     a_line,
  input  line_t                     b_line,
  input  logic [`ICACHE_QSEL_W-1:0] a_qsel,
  input  logic [`ICACHE_QSEL_W-1:0] b_qsel,
  output logic                      a_hit,
  output logic                      b_hit,
  output quarter_t                  a_quarter,
  output quarter_t                  b_quarter
);

  // quarter 0 at the bottom of the line
  function automatic quarter_t pick(line_t line, logic [`ICACHE_QSEL_W-1:0] qsel,
                                    logic hit);
    quarter_t q;
    q = line[qsel*`ICACHE_QUARTER_W +: `ICACHE_QUARTER_W];
    return hit ? q : '0;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      a_hit     <= 1'b0;
      b_hit     <= 1'b0;
      a_quarter <= '0;
      b_quarter <= '0;
    end else begin
      a_hit     <= a_hit_in;
      b_hit     <= b_hit_in;
      a_quarter <= pick(a_line, a_qsel, a_hit_in);
      b_quarter <= pick(b_line, b_qsel, b_hit_in);
    end
  end

endmodule

// ==== logic/fetch_stall_hold.sv ====
// output hold register of one fetch port
// freezes while the fetch unit stalls, flushes to zero on an exception

`timescale 1ns/1ns

module fetch_stall_hold
  import icache_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fstall,
  input  logic     except,
  input  logic     hit_in,
  input  quarter_t data_in,
  output logic     hit,
  output quarter_t data
);

  always_ff @(posedge clk) begin
    if (rst || except) begin
      // exception wins over a stall
      hit  <= 1'b0;
      data <= '0;
    end else if (!fstall) begin
      hit  <= hit_in;
      data <= data_in;
    end
  end

endmodule

// ==== logic/icache_fetch_store.sv ====
// top of the fetch cache line store
// read ports A and B, line fill, invalidate, presence check and expunge report

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_fetch_store
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        a_read_en,
  input  fetch_addr_t a_addr,
  input  logic        b_read_en,
  input  fetch_addr_t b_addr,
  input  logic        a_fstall,
  input  logic        a_except,
  input  logic        b_fstall,
  input  logic        b_except,
  input  logic        fill_wen,
  input  line_addr_t  fill_addr,
  input  half_line_t  fill_data,
  input  logic        invalidate,
  input  logic        chk_en,
  input  line_addr_t  chk_addr,
  output logic        a_hit,
  output quarter_t    a_data,
  output logic        b_hit,
  output quarter_t    b_data,
  output logic        chk_hit,
  output logic        expun_wen,
  output line_addr_t  expun_addr
);

  logic        a_read_en_q;
  logic        b_read_en_q;
  fetch_addr_t a_addr_q;
  fetch_addr_t b_addr_q;

  logic       commit_wen;
  logic       commit_inv;
  line_addr_t commit_addr;
  line_t      commit_line;

  logic                      ram_a_hit;
  logic                      ram_b_hit;
  line_t                     ram_a_line;
  line_t                     ram_b_line;
  logic [`ICACHE_QSEL_W-1:0] ram_a_qsel;
  logic [`ICACHE_QSEL_W-1:0] ram_b_qsel;

  logic     sel_a_hit;
  logic     sel_b_hit;
  quarter_t sel_a_quarter;
  quarter_t sel_b_quarter;

  // request register in front of the arrays
  always_ff @(posedge clk) begin
    if (rst) begin
      a_read_en_q <= 1'b0;
      b_read_en_q <= 1'b0;
    end else begin
      a_read_en_q <= a_read_en;
      b_read_en_q <= b_read_en;
    end
  end

  always_ff @(posedge clk) begin
    a_addr_q <= a_addr;
    b_addr_q <= b_addr;
  end

  icache_fill_assembler fill_asm (
    .clk(clk), .rst(rst),
    .fill_wen(fill_wen), .invalidate(invalidate),
    .fill_addr(fill_addr), .fill_data(fill_data),
    .commit_wen(commit_wen), .commit_inv(commit_inv),
    .commit_addr(commit_addr), .commit_line(commit_line)
  );

  icache_line_ram line_ram (
    .clk(clk), .rst(rst),
    .a_read_en(a_read_en_q), .b_read_en(b_read_en_q),
    .a_addr(a_addr_q), .b_addr(b_addr_q),
    .commit_wen(commit_wen), .commit_inv(commit_inv),
    .commit_addr(commit_addr), .commit_line(commit_line),
    .chk_en(chk_en), .chk_addr(chk_addr),
    .a_hit(ram_a_hit), .b_hit(ram_b_hit),
    .a_line(ram_a_line), .b_line(ram_b_line),
    .a_qsel(ram_a_qsel), .b_qsel(ram_b_qsel),
    .chk_hit(chk_hit), .expun_wen(expun_wen), .expun_addr(expun_addr)
  );

  icache_quarter_select qsel (
    .clk(clk), .rst(rst),
    .a_hit_in(ram_a_hit), .b_hit_in(ram_b_hit),
    .a_line(ram_a_line), .b_line(ram_b_line),
    .a_qsel(ram_a_qsel), .b_qsel(ram_b_qsel),
    .a_hit(sel_a_hit), .b_hit(sel_b_hit),
    .a_quarter(sel_a_quarter), .b_quarter(sel_b_quarter)
  );

  // one hold stage per fetch port
  fetch_stall_hold hold_a (
    .clk(clk), .rst(rst), .fstall(a_fstall), .except(a_except),
    .hit_in(sel_a_hit), .data_in(sel_a_quarter), .hit(a_hit), .data(a_data)
  );

  fetch_stall_hold hold_b (
    .clk(clk), .rst(rst), .fstall(b_fstall), .except(b_except),
    .hit_in(sel_b_hit), .data_in(sel_b_quarter), .hit(b_hit), .data(b_data)
  );

endmodule

// ==== dv/icache_tests.svh ====
// directed tests of the fetch cache line store
// included into the testbench module and uses its drive and compare tasks

task automatic test_reset_reads();
  check_hit(a_hit, 1'b0, "a_hit after reset");
  check_quarter(a_data, '0, "a_data after reset");
  check_hit(b_hit, 1'b0, "b_hit after reset");
  check_quarter(b_data, '0, "b_data after reset");
  check_hit(chk_hit, 1'b0, "chk_hit after reset");
  check_hit(expun_wen, 1'b0, "expun_wen after reset");
  read_both(1'b1, 16'h0040, 1'b1, 16'h1234);
endtask

task automatic test_fill_and_read();
  line_t line;
  tag_t  tag;
  for (int i = 0; i < `ICACHE_SETS; i++) begin
    tag  = tag_t'($urandom);
    line = {$urandom, $urandom, $urandom, $urandom};
    fill_line({tag, index_t'(i)}, line);
  end
  // A walks up and B walks down, so the ports never share an address
  for (int i = 0; i < `ICACHE_SETS; i++) begin
    for (int q = 0; q < 4; q++) begin
      read_both(1'b1, resident_addr(i, q), 1'b1, resident_addr(`ICACHE_SETS - 1 - i, 3 - q));
    end
  end
  // resident lines without read_en give no hit
  read_both(1'b0, resident_addr(0, 0), 1'b0, resident_addr(1, 1));
endtask

task automatic test_stall_except();
  quarter_t held;
  quarter_t b_exp;
  read_both(1'b1, resident_addr(3, 1), 1'b0, '0);
  held     = expect_quarter(1'b1, resident_addr(3, 1));
  b_exp    = expect_quarter(1'b1, resident_addr(9, 2));
  a_fstall = 1'b1;
  // new reads flow underneath the frozen A result
  a_read_en = 1'b1;
  a_addr    = resident_addr(5, 0);
  b_read_en = 1'b1;
  b_addr    = resident_addr(9, 2);
  for (int n = 0; n < 4; n++) begin
    next_cycle();
    a_read_en = 1'b0;
    b_read_en = 1'b0;
    check_hit(a_hit, 1'b1, "a_hit under stall");
    check_quarter(a_data, held, "a_data under stall");
  end
  check_hit(b_hit, 1'b1, "b_hit beside stalled A");
  check_quarter(b_data, b_exp, "b_data beside stalled A");
  // B holds its result while A flushes even though it still stalls
  b_fstall = 1'b1;
  a_except = 1'b1;
  next_cycle();
  a_except = 1'b0;
  check_hit(a_hit, 1'b0, "a_hit after except");
  check_quarter(a_data, '0, "a_data after except");
  check_hit(b_hit, 1'b1, "b_hit after A except");
  check_quarter(b_data, b_exp, "b_data after A except");
  a_fstall = 1'b0;
  b_fstall = 1'b0;
  read_both(1'b1, resident_addr(5, 0), 1'b1, resident_addr(9, 3));
endtask

task automatic test_eviction();
  line_addr_t old_la;
  line_addr_t new_la;
  old_la = {model_tag[6], index_t'(6)};
  new_la = {model_tag[6] ^ (tag_t'($urandom) | tag_t'(1)), index_t'(6)};
  fill_line(new_la, {$urandom, $urandom, $urandom, $urandom});
  read_both(1'b1, {old_la, 2'd2}, 1'b1, {new_la, 2'd2});
endtask

task automatic test_invalidate_check();
  line_addr_t gone;
  line_addr_t kept;
  line_addr_t wrong;
  gone  = {model_tag[2], index_t'(2)};
  kept  = {model_tag[11], index_t'(11)};
  wrong = {~model_tag[11], index_t'(11)};
  check_presence(gone);
  invalidate_line(gone);
  invalidate_line(wrong);
  read_both(1'b1, {gone, 2'd0}, 1'b1, {kept, 2'd3});
  check_presence(gone);
  check_presence(kept);
  check_presence(wrong);
endtask

// ==== dv/icache_tb.sv ====
// testbench of the fetch cache line store, checks against its own line model
// compile with compile.f and run icache_tb as the top

`timescale 1ns/1ns
`include "icache_params.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int CLK_HALF     = 20;
  localparam int READ_CYCLES  = 5;
  localparam int FILL_CYCLES  = 4;
  localparam int CHECK_CYCLES = 3;
  // reset, then the tests in the order they run
  localparam int TEST_CYCLES = 2 + READ_CYCLES
      + `ICACHE_SETS * (FILL_CYCLES + 4 * READ_CYCLES) + READ_CYCLES
      + 2 * READ_CYCLES + 5
      + FILL_CYCLES + READ_CYCLES
      + 4 * CHECK_CYCLES + 4 + READ_CYCLES;
  localparam int TIMEOUT_NS = TEST_CYCLES * 2 * CLK_HALF * 2;

  logic        clk = 1'b0;
  logic        rst;
  logic        a_read_en;
  fetch_addr_t a_addr;
  logic        b_read_en;
  fetch_addr_t b_addr;
  logic        a_fstall;
  logic        a_except;
  logic        b_fstall;
  logic        b_except;
  logic        fill_wen;
  line_addr_t  fill_addr;
  half_line_t  fill_data;
  logic        invalidate;
  logic        chk_en;
  line_addr_t  chk_addr;
  logic        a_hit;
  quarter_t    a_data;
  logic        b_hit;
  quarter_t    b_data;
  logic        chk_hit;
  logic        expun_wen;
  line_addr_t  expun_addr;

  int    errors = 0;
  // reference copy of the cache contents
  logic  model_valid [`ICACHE_SETS];
  tag_t  model_tag [`ICACHE_SETS];
  line_t model_line [`ICACHE_SETS];

  always #(CLK_HALF) clk = ~clk;

  icache_fetch_store dut (.*);

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_quarter(quarter_t got, quarter_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_hit(logic got, logic exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_line_addr(line_addr_t got, line_addr_t exp, string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // line address is the tag above the index
  function automatic index_t index_of(line_addr_t la);
    return la[`ICACHE_INDEX_W-1:0];
  endfunction

  function automatic tag_t tag_of(line_addr_t la);
    return la[`ICACHE_INDEX_W +: `ICACHE_TAG_W];
  endfunction

  function automatic logic model_hit(line_addr_t la);
    return model_valid[index_of(la)] && (model_tag[index_of(la)] == tag_of(la));
  endfunction

  function automatic logic expect_hit(logic en, fetch_addr_t fa);
    return en && model_hit(fa[`ICACHE_ADDR_W-1:`ICACHE_QSEL_W]);
  endfunction

  function automatic quarter_t expect_quarter(logic en, fetch_addr_t fa);
    line_t line;
    line = model_line[index_of(fa[`ICACHE_ADDR_W-1:`ICACHE_QSEL_W])];
    if (!expect_hit(en, fa)) begin
      return '0;
    end
    return line[fa[`ICACHE_QSEL_W-1:0] * `ICACHE_QUARTER_W +: `ICACHE_QUARTER_W];
  endfunction

  // fetch address of a quarter of the line the model holds at idx
  function automatic fetch_addr_t resident_addr(int idx, int q);
    return {model_tag[idx], index_t'(idx), q[`ICACHE_QSEL_W-1:0]};
  endfunction

  // one request per port with the result due after the fourth edge
  task automatic read_both(logic a_en, fetch_addr_t aa, logic b_en, fetch_addr_t ba);
    logic     a_hit_exp;
    logic     b_hit_exp;
    quarter_t a_exp;
    quarter_t b_exp;
    a_hit_exp = expect_hit(a_en, aa);
    b_hit_exp = expect_hit(b_en, ba);
    a_exp     = expect_quarter(a_en, aa);
    b_exp     = expect_quarter(b_en, ba);
    a_read_en = a_en;
    a_addr    = aa;
    b_read_en = b_en;
    b_addr    = ba;
    next_cycle();
    a_read_en = 1'b0;
    b_read_en = 1'b0;
    repeat (3) next_cycle();
    check_hit(a_hit, a_hit_exp, "a_hit");
    check_quarter(a_data, a_exp, "a_data");
    check_hit(b_hit, b_hit_exp, "b_hit");
    check_quarter(b_data, b_exp, "b_data");
  endtask

  // low half goes with the strobe and the high half on the next beat
  task automatic fill_line(line_addr_t la, line_t data);
    logic evict;
    evict     = model_valid[index_of(la)] && (model_tag[index_of(la)] != tag_of(la));
    fill_wen  = 1'b1;
    fill_addr = la;
    fill_data = data[$bits(half_line_t)-1:0];
    next_cycle();
    fill_wen  = 1'b0;
    fill_data = data[$bits(line_t)-1 -: $bits(half_line_t)];
    repeat (2) next_cycle();
    check_hit(expun_wen, evict, "expun_wen after commit");
    if (evict) begin
      check_line_addr(expun_addr, {model_tag[index_of(la)], index_of(la)}, "expun_addr");
    end
    model_valid[index_of(la)] = 1'b1;
    model_tag[index_of(la)]   = tag_of(la);
    model_line[index_of(la)]  = data;
    next_cycle();
    check_hit(expun_wen, 1'b0, "expun_wen one cycle after commit");
  endtask

  task automatic invalidate_line(line_addr_t la);
    invalidate = 1'b1;
    fill_addr  = la;
    next_cycle();
    invalidate = 1'b0;
    next_cycle();
    if (model_hit(la)) begin
      model_valid[index_of(la)] = 1'b0;
    end
  endtask

  // chk_hit follows one edge after the sampling edge
  task automatic check_presence(line_addr_t la);
    chk_en   = 1'b1;
    chk_addr = la;
    next_cycle();
    chk_en = 1'b0;
    next_cycle();
    check_hit(chk_hit, model_hit(la), "chk_hit");
    next_cycle();
    check_hit(chk_hit, 1'b0, "chk_hit with chk_en low");
  endtask

  `include "icache_tests.svh"

  initial begin
    void'($urandom(61));
    rst        = 1'b1;
    a_read_en  = 1'b0;
    a_addr     = '0;
    b_read_en  = 1'b0;
    b_addr     = '0;
    a_fstall   = 1'b0;
    a_except   = 1'b0;
    b_fstall   = 1'b0;
    b_except   = 1'b0;
    fill_wen   = 1'b0;
    fill_addr  = '0;
    fill_data  = '0;
    invalidate = 1'b0;
    chk_en     = 1'b0;
    chk_addr   = '0;
    for (int i = 0; i < `ICACHE_SETS; i++) begin
      model_valid[i] = 1'b0;
    end
    repeat (2) next_cycle();
    rst = 1'b0;
    fork
      begin
        #(TIMEOUT_NS);
        $display("timeout: tests still running after %0d ns, %0d errors", TIMEOUT_NS, errors);
        $display("FAIL: see errors above");
        $finish;
      end
      begin
        test_reset_reads();
        test_fill_and_read();
        test_stall_except();
        test_eviction();
        test_invalidate_check();
      end
    join_any
    disable fork;
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
+incdir+dv
logic/icache_pkg.sv
logic/icache_fill_assembler.sv
logic/icache_line_ram.sv
logic/icache_quarter_select.sv
logic/fetch_stall_hold.sv
logic/icache_fetch_store.sv
dv/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache_fetch_store

sources:
  - include_dirs:
      - logic
    files:
      - logic/icache_pkg.sv
      - logic/icache_fill_assembler.sv
      - logic/icache_line_ram.sv
      - logic/icache_quarter_select.sv
      - logic/fetch_stall_hold.sv
      - logic/icache_fetch_store.sv

  - target: simulation
    include_dirs:
      - logic
      - dv
    files:
      - dv/icache_tb.sv
